//--- rtl/cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int snes_addr_w = 24;
  localparam int rom_addr_w = 23;
  localparam int rom_data_w = 16;
  localparam int byte_w = 8;

  // Samples kept per console strobe
  localparam int sync_depth = 6;

  ////////////////////////////////////////
  // Arbiter timing
  ////////////////////////////////////////

  localparam int wait_w = 4;

  // Loaded into the wait counter, one more cycle than the value
  localparam logic [wait_w-1:0] rd_wait = 4'd4;
  localparam logic [wait_w-1:0] wr_wait1 = 4'd2;
  localparam logic [wait_w-1:0] wr_wait2 = 4'd3;
  localparam logic [wait_w-1:0] mcu_wait = 4'd6;
  localparam logic [wait_w-1:0] mcu_tail = 4'd2;

  // Save RAM lives in the top part of the PSRAM
  localparam logic [snes_addr_w-1:0] saveram_base = 24'he00000;

  typedef enum logic {
    map_hirom,
    map_lorom
  } mapper_t;

  typedef enum logic [4:0] {
    st_idle,
    st_snes_rd_addr,
    st_snes_rd_wait,
    st_snes_rd_end,
    st_snes_wr_addr,
    st_snes_wr_wait1,
    st_snes_wr_data,
    st_snes_wr_wait2,
    st_snes_wr_end,
    st_mcu_rd_addr,
    st_mcu_rd_wait,
    st_mcu_rd_wait2,
    st_mcu_rd_end,
    st_mcu_wr_addr,
    st_mcu_wr_wait,
    st_mcu_wr_wait2,
    st_mcu_wr_end
  } arb_state_t;

endpackage

//--- rtl/snes_bus_sync.sv
`timescale 1ns/10ps

module snes_bus_sync (
  input  logic CLK2,
  input  logic arst_n,
  input  logic snes_read,
  input  logic snes_write,
  input  logic snes_cpu_clk,
  output logic rd_start,
  output logic wr_start,
  output logic cycle_start,
  output logic cycle_end
);

  logic [cart_pkg::sync_depth-1:0] read_hist;
  logic [cart_pkg::sync_depth-1:0] write_hist;
  logic [cart_pkg::sync_depth-1:0] clk_hist;
  logic [cart_pkg::sync_depth-1:0] fall_pat;
  logic [cart_pkg::sync_depth-1:0] rise_pat;

  // Five stable samples, then the new level
  assign fall_pat = {{(cart_pkg::sync_depth-1){1'b1}}, 1'b0};
  assign rise_pat = ~fall_pat;

  // Strobes idle high, CPU clock assumed low out of reset
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_hist <= '1;
      write_hist <= '1;
      clk_hist <= '0;
    end else begin
      read_hist <= {read_hist[cart_pkg::sync_depth-2:0], snes_read};
      write_hist <= {write_hist[cart_pkg::sync_depth-2:0], snes_write};
      clk_hist <= {clk_hist[cart_pkg::sync_depth-2:0], snes_cpu_clk};
    end
  end

  assign rd_start = (read_hist == fall_pat);
  assign wr_start = (write_hist == fall_pat);

  // Glitches shorter than the history never match
  assign cycle_start = (clk_hist == rise_pat);
  assign cycle_end = (clk_hist == fall_pat);

endmodule

//--- rtl/cart_addr_map.sv
`timescale 1ns/10ps

module cart_addr_map (
  input  cart_pkg::mapper_t                 mapper,
  input  logic [cart_pkg::snes_addr_w-1:0]  rom_mask,
  input  logic [cart_pkg::snes_addr_w-1:0]  saveram_mask,
  input  logic [cart_pkg::snes_addr_w-1:0]  snes_addr,
  output logic [cart_pkg::snes_addr_w-1:0]  mapped_addr,
  output logic                              is_rom,
  output logic                              is_saveram
);

  logic [7:0] bank;
  logic [15:0] offset;

  logic hi_is_rom;
  logic hi_is_saveram;
  logic [cart_pkg::snes_addr_w-1:0] hi_rom_addr;
  logic [cart_pkg::snes_addr_w-1:0] hi_sram_addr;

  logic lo_sram_bank;
  logic lo_is_rom;
  logic lo_is_saveram;
  logic [cart_pkg::snes_addr_w-1:0] lo_rom_addr;
  logic [cart_pkg::snes_addr_w-1:0] lo_sram_addr;

  assign bank = snes_addr[23:16];
  assign offset = snes_addr[15:0];

  ////////////////////////////////////////
  // HiROM
  ////////////////////////////////////////

  assign hi_is_rom = snes_addr[22] | offset[15];
  // Banks 20-3F, offsets 6000-7FFF
  assign hi_is_saveram = (bank[7:5] == 3'b001) & (offset[15:13] == 3'b011);
  assign hi_rom_addr = snes_addr & rom_mask;
  assign hi_sram_addr = cart_pkg::saveram_base
                      + ({6'b0, bank[4:0], offset[12:0]} & saveram_mask);

  ////////////////////////////////////////
  // LoROM
  ////////////////////////////////////////

  // Banks 70-7D hold save RAM in their lower half
  assign lo_sram_bank = (bank >= 8'h70) & (bank <= 8'h7d);
  assign lo_is_rom = offset[15] & ~lo_sram_bank;
  assign lo_is_saveram = lo_sram_bank & ~offset[15];
  assign lo_rom_addr = {2'b0, bank[6:0], offset[14:0]} & rom_mask;
  assign lo_sram_addr = cart_pkg::saveram_base
                      + ({4'b0, bank[4:0], offset[14:0]} & saveram_mask);

  always_comb begin
    case (mapper)
      cart_pkg::map_lorom: begin
        is_rom = lo_is_rom;
        is_saveram = lo_is_saveram;
        mapped_addr = lo_is_saveram ? lo_sram_addr : lo_rom_addr;
      end
      default: begin
        is_rom = hi_is_rom;
        is_saveram = hi_is_saveram;
        mapped_addr = hi_is_saveram ? hi_sram_addr : hi_rom_addr;
      end
    endcase
  end

endmodule

//--- rtl/rom_arbiter.sv
`timescale 1ns/10ps

module rom_arbiter (
  input  logic                              CLK2,
  input  logic                              arst_n,
  input  logic                              rd_start,
  input  logic                              wr_start,
  input  logic                              cycle_start,
  input  logic                              cycle_end,
  input  logic [cart_pkg::snes_addr_w-1:0]  mapped_addr,
  input  logic                              is_saveram,
  input  logic [cart_pkg::byte_w-1:0]       snes_data_in,
  input  logic [cart_pkg::snes_addr_w-1:0]  mcu_addr,
  input  logic [cart_pkg::byte_w-1:0]       mcu_dout,
  input  logic                              mcu_rrq,
  input  logic                              mcu_wrq,
  input  logic [cart_pkg::rom_data_w-1:0]   rom_data_in,
  input  logic                              byte_sel,
  output cart_pkg::arb_state_t              state,
  output logic [cart_pkg::snes_addr_w-1:0]  held_addr,
  output logic [cart_pkg::byte_w-1:0]       wr_data,
  output logic                              we_req,
  output logic                              snes_cycle_write,
  output logic                              need_snes_addr,
  output logic [cart_pkg::byte_w-1:0]       snes_din,
  output logic [cart_pkg::byte_w-1:0]       mcu_din,
  output logic                              mcu_rdy
);

  logic [cart_pkg::wait_w-1:0] delay;
  logic delay_done;
  logic rd_force;
  logic mcu_rd_pend;
  logic mcu_wr_pend;
  logic [cart_pkg::byte_w-1:0] rom_byte;

  assign delay_done = (delay == '0);
  // Read strobe edge also restarts a read, in case it trails the clock edge
  assign rd_force = (cycle_start | rd_start) & ~wr_start;
  // Odd byte on the low lane
  assign rom_byte = byte_sel ? rom_data_in[7:0] : rom_data_in[15:8];

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state <= cart_pkg::st_idle;
      delay <= '0;
      we_req <= 1'b0;
      snes_cycle_write <= 1'b0;
    end else if (wr_start | rd_force) begin
      // Console always wins, an MCU access in flight is dropped
      state <= wr_start ? cart_pkg::st_snes_wr_addr : cart_pkg::st_snes_rd_addr;
      we_req <= 1'b0;
      snes_cycle_write <= 1'b0;
    end else begin
      delay <= delay - 1'b1;
      case (state)
        cart_pkg::st_idle: begin
          if (mcu_rd_pend) begin
            state <= cart_pkg::st_mcu_rd_addr;
          end else if (mcu_wr_pend) begin
            state <= cart_pkg::st_mcu_wr_addr;
          end
        end
        cart_pkg::st_snes_rd_addr: begin
          state <= cart_pkg::st_snes_rd_wait;
          delay <= cart_pkg::rd_wait;
        end
        cart_pkg::st_snes_rd_wait: begin
          if (delay_done) state <= cart_pkg::st_snes_rd_end;
        end
        cart_pkg::st_snes_wr_addr: begin
          // Only save RAM is writable from the console
          we_req <= is_saveram;
          snes_cycle_write <= 1'b1;
          state <= cart_pkg::st_snes_wr_wait1;
          delay <= cart_pkg::wr_wait1;
        end
        cart_pkg::st_snes_wr_wait1: begin
          if (delay_done) state <= cart_pkg::st_snes_wr_data;
        end
        cart_pkg::st_snes_wr_data: begin
          state <= cart_pkg::st_snes_wr_wait2;
          delay <= cart_pkg::wr_wait2;
        end
        cart_pkg::st_snes_wr_wait2: begin
          if (delay_done) state <= cart_pkg::st_snes_wr_end;
        end
        cart_pkg::st_snes_wr_end: begin
          state <= cart_pkg::st_idle;
          we_req <= 1'b0;
          snes_cycle_write <= 1'b0;
        end
        cart_pkg::st_mcu_rd_addr: begin
          state <= cart_pkg::st_mcu_rd_wait;
          delay <= cart_pkg::mcu_wait;
        end
        cart_pkg::st_mcu_rd_wait: begin
          if (delay_done) begin
            state <= cart_pkg::st_mcu_rd_wait2;
            delay <= cart_pkg::mcu_tail;
          end
        end
        cart_pkg::st_mcu_rd_wait2: begin
          if (delay_done) state <= cart_pkg::st_mcu_rd_end;
        end
        cart_pkg::st_mcu_wr_addr: begin
          we_req <= 1'b1;
          state <= cart_pkg::st_mcu_wr_wait;
          delay <= cart_pkg::mcu_wait;
        end
        cart_pkg::st_mcu_wr_wait: begin
          if (delay_done) begin
            we_req <= 1'b0;
            state <= cart_pkg::st_mcu_wr_wait2;
            delay <= cart_pkg::mcu_tail;
          end
        end
        cart_pkg::st_mcu_wr_wait2: begin
          if (delay_done) state <= cart_pkg::st_mcu_wr_end;
        end
        default: state <= cart_pkg::st_idle;
      endcase
    end
  end

  // Pending flags survive a console pre-emption, so the access is retried
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == cart_pkg::st_mcu_rd_end || state == cart_pkg::st_mcu_wr_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      need_snes_addr <= 1'b0;
    end else if (cycle_end) begin
      need_snes_addr <= 1'b1;
    end else if (state == cart_pkg::st_snes_rd_end || state == cart_pkg::st_snes_wr_end) begin
      need_snes_addr <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Address and data capture
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    case (state)
      cart_pkg::st_idle: held_addr <= mapped_addr;
      cart_pkg::st_snes_rd_wait, cart_pkg::st_snes_rd_end: snes_din <= rom_byte;
      cart_pkg::st_snes_wr_data: wr_data <= snes_data_in;
      cart_pkg::st_mcu_rd_addr: held_addr <= mcu_addr;
      cart_pkg::st_mcu_rd_wait: mcu_din <= rom_byte;
      cart_pkg::st_mcu_wr_addr: begin
        held_addr <= mcu_addr;
        wr_data <= mcu_dout;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- rtl/psram_port.sv
`timescale 1ns/10ps

module psram_port (
  input  logic [cart_pkg::snes_addr_w-1:0]  mapped_addr,
  input  logic [cart_pkg::snes_addr_w-1:0]  held_addr,
  input  logic                              need_snes_addr,
  input  logic                              snes_cpu_clk,
  input  logic                              we_req,
  input  logic                              snes_cycle_write,
  input  logic [cart_pkg::byte_w-1:0]       wr_data,
  output logic [cart_pkg::rom_addr_w-1:0]   rom_addr,
  output logic [cart_pkg::rom_data_w-1:0]   rom_data_out,
  output logic                              rom_data_oe,
  output logic                              rom_we,
  output logic                              rom_bhe,
  output logic                              rom_ble,
  output logic                              byte_sel
);

  logic show_snes_addr;
  logic [cart_pkg::snes_addr_w-1:0] byte_addr;

  // Live console address while the CPU clock is high
  assign show_snes_addr = snes_cpu_clk & need_snes_addr;
  assign byte_addr = show_snes_addr ? mapped_addr : held_addr;

  assign rom_addr = byte_addr[cart_pkg::snes_addr_w-1:1];
  assign byte_sel = byte_addr[0];

  // Never write behind a console read address
  assign rom_we = ~we_req | (show_snes_addr & ~snes_cycle_write);
  assign rom_data_oe = ~rom_we;

  assign rom_data_out = byte_sel ? {{cart_pkg::byte_w{1'b0}}, wr_data}
                                 : {wr_data, {cart_pkg::byte_w{1'b0}}};

  // Both lanes enabled for reads, one lane for writes
  assign rom_bhe = ~rom_we & byte_sel;
  assign rom_ble = ~rom_we & ~byte_sel;

endmodule

//--- rtl/cart_main.sv
`timescale 1ns/10ps

module cart_main (
  input  logic                              CLK2,
  input  logic                              arst_n,
  input  cart_pkg::mapper_t                 mapper,
  input  logic [cart_pkg::snes_addr_w-1:0]  rom_mask,
  input  logic [cart_pkg::snes_addr_w-1:0]  saveram_mask,
  input  logic [cart_pkg::snes_addr_w-1:0]  snes_addr,
  input  logic                              snes_read,
  input  logic                              snes_write,
  input  logic                              snes_cs,
  input  logic                              snes_cpu_clk,
  input  logic [cart_pkg::byte_w-1:0]       snes_data_in,
  input  logic [cart_pkg::snes_addr_w-1:0]  mcu_addr,
  input  logic [cart_pkg::byte_w-1:0]       mcu_dout,
  input  logic                              mcu_rrq,
  input  logic                              mcu_wrq,
  input  logic [cart_pkg::rom_data_w-1:0]   rom_data_in,
  output logic [cart_pkg::byte_w-1:0]       snes_data_out,
  output logic                              snes_databus_oe,
  output logic                              snes_databus_dir,
  output logic [cart_pkg::byte_w-1:0]       mcu_din,
  output logic                              mcu_rdy,
  output logic [cart_pkg::rom_addr_w-1:0]   rom_addr,
  output logic [cart_pkg::rom_data_w-1:0]   rom_data_out,
  output logic                              rom_data_oe,
  output logic                              rom_we,
  output logic                              rom_bhe,
  output logic                              rom_ble,
  output logic                              rom_ce,
  output logic                              rom_oe
);

  logic rd_start;
  logic wr_start;
  logic cycle_start;
  logic cycle_end;
  logic [cart_pkg::snes_addr_w-1:0] mapped_addr;
  logic is_rom;
  logic is_saveram;
  logic [cart_pkg::snes_addr_w-1:0] held_addr;
  logic [cart_pkg::byte_w-1:0] wr_data;
  logic we_req;
  logic snes_cycle_write;
  logic need_snes_addr;
  logic byte_sel;

  snes_bus_sync snes_bus_sync_i (
    .CLK2         (CLK2),
    .arst_n       (arst_n),
    .snes_read    (snes_read),
    .snes_write   (snes_write),
    .snes_cpu_clk (snes_cpu_clk),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end)
  );

  cart_addr_map cart_addr_map_i (
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .snes_addr    (snes_addr),
    .mapped_addr  (mapped_addr),
    .is_rom       (is_rom),
    .is_saveram   (is_saveram)
  );

  rom_arbiter rom_arbiter_i (
    .CLK2             (CLK2),
    .arst_n           (arst_n),
    .rd_start         (rd_start),
    .wr_start         (wr_start),
    .cycle_start      (cycle_start),
    .cycle_end        (cycle_end),
    .mapped_addr      (mapped_addr),
    .is_saveram       (is_saveram),
    .snes_data_in     (snes_data_in),
    .mcu_addr         (mcu_addr),
    .mcu_dout         (mcu_dout),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .rom_data_in      (rom_data_in),
    .byte_sel         (byte_sel),
    .state            (),
    .held_addr        (held_addr),
    .wr_data          (wr_data),
    .we_req           (we_req),
    .snes_cycle_write (snes_cycle_write),
    .need_snes_addr   (need_snes_addr),
    .snes_din         (snes_data_out),
    .mcu_din          (mcu_din),
    .mcu_rdy          (mcu_rdy)
  );

  psram_port psram_port_i (
    .mapped_addr      (mapped_addr),
    .held_addr        (held_addr),
    .need_snes_addr   (need_snes_addr),
    .snes_cpu_clk     (snes_cpu_clk),
    .we_req           (we_req),
    .snes_cycle_write (snes_cycle_write),
    .wr_data          (wr_data),
    .rom_addr         (rom_addr),
    .rom_data_out     (rom_data_out),
    .rom_data_oe      (rom_data_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .byte_sel         (byte_sel)
  );

  // PSRAM always selected, WE overrides OE
  assign rom_ce = 1'b0;
  assign rom_oe = 1'b0;

  // Bus transceiver only for our own address ranges
  assign snes_databus_oe = ~((~snes_read | ~snes_write)
                             & (is_saveram | (is_rom & ~snes_cs)));
  assign snes_databus_dir = ~snes_read;

endmodule

//--- tests/psram_model.sv
`timescale 1ns/10ps

module psram_model (
  input  logic                             CLK2,
  input  logic [cart_pkg::rom_addr_w-1:0]  addr,
  input  logic [cart_pkg::rom_data_w-1:0]  din,
  input  logic                             we,
  input  logic                             bhe,
  input  logic                             ble,
  input  logic                             ce,
  input  logic                             oe,
  output logic [cart_pkg::rom_data_w-1:0]  dout
);

  // Only written words are stored, the rest come from the fill pattern
  logic [cart_pkg::rom_data_w-1:0] mem [logic [cart_pkg::rom_addr_w-1:0]];
  logic [31:0] salt;
  logic [cart_pkg::rom_data_w-1:0] wr_word;

  initial begin
    salt = '0;
    dout = '0;
  end

  task automatic load_random();
    salt = $urandom;
  endtask

  function automatic logic [cart_pkg::rom_data_w-1:0] read_word(
    input logic [cart_pkg::rom_addr_w-1:0] a
  );
    logic [31:0] h;
    if (mem.exists(a)) begin
      return mem[a];
    end
    h = ({9'd0, a} ^ salt) * 32'h9e3779b1;
    return h[31:16] ^ h[15:0];
  endfunction

  // Odd bytes sit on the low lane
  function automatic logic [cart_pkg::byte_w-1:0] peek_byte(
    input logic [cart_pkg::snes_addr_w-1:0] byte_addr
  );
    logic [cart_pkg::rom_data_w-1:0] w;
    w = read_word(byte_addr[cart_pkg::snes_addr_w-1:1]);
    return byte_addr[0] ? w[7:0] : w[15:8];
  endfunction

  // Byte lane enables are active low
  always @(negedge CLK2) begin
    if (!ce && !we) begin
      wr_word = read_word(addr);
      if (!bhe) wr_word[15:8] = din[15:8];
      if (!ble) wr_word[7:0] = din[7:0];
      mem[addr] = wr_word;
    end
    if (!ce && !oe) dout <= read_word(addr);
  end

endmodule

//--- tests/cart_main_tb.sv
`timescale 1ns/10ps

module cart_main_tb;

  logic CLK2;
  logic arst_n;
  cart_pkg::mapper_t mapper;
  logic [cart_pkg::snes_addr_w-1:0] rom_mask;
  logic [cart_pkg::snes_addr_w-1:0] saveram_mask;
  logic [cart_pkg::snes_addr_w-1:0] snes_addr;
  logic snes_read;
  logic snes_write;
  logic snes_cs;
  logic snes_cpu_clk;
  logic [cart_pkg::byte_w-1:0] snes_data_in;
  logic [cart_pkg::snes_addr_w-1:0] mcu_addr;
  logic [cart_pkg::byte_w-1:0] mcu_dout;
  logic mcu_rrq;
  logic mcu_wrq;
  logic [cart_pkg::rom_data_w-1:0] rom_data_in;
  logic [cart_pkg::byte_w-1:0] snes_data_out;
  logic snes_databus_oe;
  logic snes_databus_dir;
  logic [cart_pkg::byte_w-1:0] mcu_din;
  logic mcu_rdy;
  logic [cart_pkg::rom_addr_w-1:0] rom_addr;
  logic [cart_pkg::rom_data_w-1:0] rom_data_out;
  logic rom_data_oe;
  logic rom_we;
  logic rom_bhe;
  logic rom_ble;
  logic rom_ce;
  logic rom_oe;

  int errors;
  int checks;

  cart_main cart_main_i (
    .CLK2             (CLK2),
    .arst_n           (arst_n),
    .mapper           (mapper),
    .rom_mask         (rom_mask),
    .saveram_mask     (saveram_mask),
    .snes_addr        (snes_addr),
    .snes_read        (snes_read),
    .snes_write       (snes_write),
    .snes_cs          (snes_cs),
    .snes_cpu_clk     (snes_cpu_clk),
    .snes_data_in     (snes_data_in),
    .mcu_addr         (mcu_addr),
    .mcu_dout         (mcu_dout),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .rom_data_in      (rom_data_in),
    .snes_data_out    (snes_data_out),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir),
    .mcu_din          (mcu_din),
    .mcu_rdy          (mcu_rdy),
    .rom_addr         (rom_addr),
    .rom_data_out     (rom_data_out),
    .rom_data_oe      (rom_data_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .rom_ce           (rom_ce),
    .rom_oe           (rom_oe)
  );

  psram_model psram_model_i (
    .CLK2 (CLK2),
    .addr (rom_addr),
    .din  (rom_data_out),
    .we   (rom_we),
    .bhe  (rom_bhe),
    .ble  (rom_ble),
    .ce   (rom_ce),
    .oe   (rom_oe),
    .dout (rom_data_in)
  );

  initial begin
    CLK2 = 1'b0;
    forever #4 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////
  // Drivers and checks
  ////////////////////////////////////////

  task automatic compare_values(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      $display("mismatch %s: expected %0h, actual %0h", name, exp_val, act_val);
      errors++;
    end
  endtask

  // CPU clock low for 6 cycles, high for 18, strobe low during the high phase
  task automatic run_snes_cycle(input logic [23:0] addr, input logic write_cycle,
                                input logic [7:0] wdata, output logic [7:0] rdata,
                                output logic oe_seen, output logic dir_seen);
    @(posedge CLK2);
    snes_addr <= addr;
    snes_data_in <= wdata;
    snes_cpu_clk <= 1'b0;
    repeat (5) @(posedge CLK2);
    snes_cpu_clk <= 1'b1;
    snes_cs <= 1'b0;
    if (write_cycle) snes_write <= 1'b0;
    else snes_read <= 1'b0;
    repeat (17) @(posedge CLK2);
    @(negedge CLK2);
    rdata = snes_data_out;
    oe_seen = snes_databus_oe;
    dir_seen = snes_databus_dir;
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    snes_read <= 1'b1;
    snes_write <= 1'b1;
    snes_cs <= 1'b1;
  endtask

  task automatic mcu_request(input string name, input logic write_access,
                             input logic [23:0] addr, input logic [7:0] wdata);
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_dout <= wdata;
    if (write_access) mcu_wrq <= 1'b1;
    else mcu_rrq <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    compare_values({name, "_rdy_low"}, 32'd0, 32'(mcu_rdy));
  endtask

  task automatic wait_mcu_ready(input string name);
    int n;
    n = 0;
    while (!mcu_rdy && n < 200) begin
      @(negedge CLK2);
      n++;
    end
    if (!mcu_rdy) begin
      $display("%s: mcu_rdy did not come back within 200 cycles", name);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_values_test();
    @(negedge CLK2);
    compare_values("reset_mcu_rdy", 32'd1, 32'(mcu_rdy));
    compare_values("reset_rom_we", 32'd1, 32'(rom_we));
    compare_values("reset_rom_data_oe", 32'd0, 32'(rom_data_oe));
  endtask

  task automatic rom_read_test();
    logic [7:0] expected;
    logic [7:0] rdata;
    logic oe_seen;
    logic dir_seen;
    // HiROM C1:2345 under a 4 MB mask
    expected = psram_model_i.peek_byte(24'h012345);
    run_snes_cycle(24'hc12345, 1'b0, 8'h00, rdata, oe_seen, dir_seen);
    compare_values("hirom_read", 32'(expected), 32'(rdata));
    compare_values("hirom_read_oe", 32'd0, 32'(oe_seen));
    compare_values("hirom_read_dir", 32'd1, 32'(dir_seen));
    @(posedge CLK2);
    mapper <= cart_pkg::map_lorom;
    // LoROM 81:9234 is bank 01, offset 1234
    expected = psram_model_i.peek_byte(24'h009234);
    run_snes_cycle(24'h819234, 1'b0, 8'h00, rdata, oe_seen, dir_seen);
    compare_values("lorom_read_even", 32'(expected), 32'(rdata));
    compare_values("lorom_read_oe", 32'd0, 32'(oe_seen));
    expected = psram_model_i.peek_byte(24'h02f00f);
    run_snes_cycle(24'h05f00f, 1'b0, 8'h00, rdata, oe_seen, dir_seen);
    compare_values("lorom_read_odd", 32'(expected), 32'(rdata));
    compare_values("lorom_read_dir", 32'd1, 32'(dir_seen));
    @(posedge CLK2);
    mapper <= cart_pkg::map_hirom;
  endtask

  task automatic saveram_write_test();
    logic [7:0] neighbor;
    logic [7:0] rom_before;
    logic [7:0] rdata;
    logic oe_seen;
    logic dir_seen;
    // HiROM 21:6011 lands at E02011
    neighbor = psram_model_i.peek_byte(24'he02010);
    run_snes_cycle(24'h216011, 1'b1, 8'h5a, rdata, oe_seen, dir_seen);
    compare_values("sram_write", 32'h5a, 32'(psram_model_i.peek_byte(24'he02011)));
    compare_values("sram_write_neighbor", 32'(neighbor),
                   32'(psram_model_i.peek_byte(24'he02010)));
    run_snes_cycle(24'h216011, 1'b0, 8'h00, rdata, oe_seen, dir_seen);
    compare_values("sram_readback", 32'h5a, 32'(rdata));
    rom_before = psram_model_i.peek_byte(24'h001000);
    run_snes_cycle(24'hc01000, 1'b1, 8'h77, rdata, oe_seen, dir_seen);
    compare_values("rom_write_ignored", 32'(rom_before),
                   32'(psram_model_i.peek_byte(24'h001000)));
  endtask

  task automatic mcu_rw_test();
    logic [7:0] neighbor;
    neighbor = psram_model_i.peek_byte(24'h100201);
    mcu_request("mcu_write_even", 1'b1, 24'h100200, 8'ha5);
    wait_mcu_ready("mcu_write_even");
    compare_values("mcu_write_even", 32'ha5, 32'(psram_model_i.peek_byte(24'h100200)));
    compare_values("mcu_write_neighbor", 32'(neighbor),
                   32'(psram_model_i.peek_byte(24'h100201)));
    mcu_request("mcu_read_even", 1'b0, 24'h100200, 8'h00);
    wait_mcu_ready("mcu_read_even");
    compare_values("mcu_read_even", 32'ha5, 32'(mcu_din));
    // Odd byte goes through the low lane
    mcu_request("mcu_write_odd", 1'b1, 24'h100201, 8'h3c);
    wait_mcu_ready("mcu_write_odd");
    compare_values("mcu_write_odd_neighbor", 32'ha5,
                   32'(psram_model_i.peek_byte(24'h100200)));
    mcu_request("mcu_read_odd", 1'b0, 24'h100201, 8'h00);
    wait_mcu_ready("mcu_read_odd");
    compare_values("mcu_read_odd", 32'h3c, 32'(mcu_din));
  endtask

  task automatic preempt_test();
    logic [7:0] exp_mcu;
    logic [7:0] exp_snes;
    logic [7:0] rdata;
    logic oe_seen;
    logic dir_seen;
    exp_mcu = psram_model_i.peek_byte(24'h012346);
    exp_snes = psram_model_i.peek_byte(24'h008001);
    // MCU read still in its wait states when the console cycle starts
    mcu_request("preempt_mcu", 1'b0, 24'h012346, 8'h00);
    run_snes_cycle(24'hc08001, 1'b0, 8'h00, rdata, oe_seen, dir_seen);
    compare_values("preempt_snes_read", 32'(exp_snes), 32'(rdata));
    wait_mcu_ready("preempt_mcu");
    compare_values("preempt_mcu_read", 32'(exp_mcu), 32'(mcu_din));
  endtask

  task automatic bus_enable_test();
    logic [7:0] rdata;
    logic oe_seen;
    logic dir_seen;
    @(negedge CLK2);
    compare_values("idle_oe", 32'd1, 32'(snes_databus_oe));
    // HiROM bank 00 below 8000 is neither ROM nor save RAM
    run_snes_cycle(24'h002100, 1'b0, 8'h00, rdata, oe_seen, dir_seen);
    compare_values("unmapped_oe", 32'd1, 32'(oe_seen));
    compare_values("unmapped_dir", 32'd1, 32'(dir_seen));
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(57));
    errors = 0;
    checks = 0;
    arst_n = 1'b1;
    mapper = cart_pkg::map_hirom;
    rom_mask = 24'h3fffff;
    saveram_mask = 24'h01ffff;
    snes_addr = '0;
    snes_read = 1'b1;
    snes_write = 1'b1;
    snes_cs = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_data_in = '0;
    mcu_addr = '0;
    mcu_dout = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    @(posedge CLK2);
    psram_model_i.load_random();
    arst_n <= 1'b0;
    repeat (5) @(posedge CLK2);
    arst_n <= 1'b1;
    reset_values_test();
    rom_read_test();
    saveram_write_test();
    mcu_rw_test();
    preempt_test();
    bus_enable_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Six tests, 400 cycles each
  initial begin
    repeat (6 * 400) @(posedge CLK2);
    $display("watchdog expired, the tests did not finish in %0d cycles", 6 * 400);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- cart_main.f
rtl/cart_pkg.sv
rtl/snes_bus_sync.sv
rtl/cart_addr_map.sv
rtl/rom_arbiter.sv
rtl/psram_port.sv
rtl/cart_main.sv
tests/psram_model.sv
tests/cart_main_tb.sv

//--- Makefile
# Verilator build and run of the cart_main testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module cart_main_tb -f cart_main.f \
		-Mdir obj_dir -o cart_main_sim
	./obj_dir/cart_main_sim | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
